/* all.f */
bp_pkg.sv
gselect_predictor.sv
local_predictor.sv
choice_table.sv
bp_control.sv
tournament_predictor.sv
tournament_props.sv
bp_checker.sv
tb_tournament.sv

/* bp_checker.sv */
`timescale 1ns/100ps

module bp_checker (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::pc_t   pc_to_predict,
    input  bp_pkg::pc_t   pc_to_update,
    input  logic          is_branch,
    input  logic          branch_taken,
    input  logic          prediction,
    input  bp_pkg::stat_t branch_count,
    input  bp_pkg::stat_t mispredict_count,
    input  logic          expect_valid,
    input  bp_pkg::stat_t expect_total,
    output int            error_count
);

    bp_pkg::ctr_t   g_pht   [bp_pkg::GSEL_ENTRIES];
    bp_pkg::ghist_t g_hist;
    bp_pkg::lhist_t l_hist  [bp_pkg::LHT_ENTRIES];
    bp_pkg::ctr_t   l_pht   [bp_pkg::PHT_ENTRIES];
    bp_pkg::ctr_t   chooser [bp_pkg::LHT_ENTRIES];
    bp_pkg::stat_t  m_branches;
    bp_pkg::stat_t  m_misses;
    logic           branch_seen; // resolved at the last edge, counted at this one.
    logic           miss_seen;

    initial error_count = 0;

    function automatic bp_pkg::ctr_t saturate(bp_pkg::ctr_t c, logic up);
        bp_pkg::ctr_t nxt;
        nxt = c;
        if (up && c != 2'b11) begin
            nxt = c + 2'b01;
        end
        if (!up && c != 2'b00) begin
            nxt = c - 2'b01;
        end
        return nxt;
    endfunction

    function automatic logic lookup(bp_pkg::pc_t pc);
        bp_pkg::pc_idx_t   i;
        bp_pkg::gsel_idx_t gi;
        i  = pc[bp_pkg::PC_IDX_W-1:0];
        gi = {g_hist, i};
        return chooser[i][1] ? g_pht[gi][1] : l_pht[l_hist[i]][1];
    endfunction

    task automatic mismatch(string msg);
        error_count++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        bp_pkg::pc_idx_t   ui;
        bp_pkg::gsel_idx_t gi;
        bp_pkg::lhist_t    lh;
        logic              exp_pred;
        logic              g_up;
        logic              l_up;
        logic              final_up;
        if (rst) begin
            for (int i = 0; i < bp_pkg::GSEL_ENTRIES; i++) begin
                g_pht[i] = 2'b01;
            end
            for (int i = 0; i < bp_pkg::LHT_ENTRIES; i++) begin
                l_hist[i]  = '0;
                chooser[i] = 2'b01; // weakly local.
            end
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                l_pht[i] = 2'b01;
            end
            g_hist      = '0;
            m_branches  = '0;
            m_misses    = '0;
            branch_seen = 1'b0;
            miss_seen   = 1'b0;
        end else begin
            exp_pred = lookup(pc_to_predict);
            if (prediction !== exp_pred) begin
                mismatch($sformatf("prediction for pc %h is %b, expected %b",
                                   pc_to_predict, prediction, exp_pred));
            end
            if (branch_count !== m_branches) begin
                mismatch($sformatf("branch_count is %0d, expected %0d",
                                   branch_count, m_branches));
            end
            if (mispredict_count !== m_misses) begin
                mismatch($sformatf("mispredict_count is %0d, expected %0d",
                                   mispredict_count, m_misses));
            end
            if (expect_valid && branch_count !== expect_total) begin
                mismatch($sformatf("branch_count is %0d, the stimulus table gives %0d",
                                   branch_count, expect_total));
            end
            if (branch_seen && m_branches != 16'hffff) begin
                m_branches = m_branches + 16'd1;
            end
            if (miss_seen && m_misses != 16'hffff) begin
                m_misses = m_misses + 16'd1;
            end
            branch_seen = is_branch;
            miss_seen   = 1'b0;
            if (is_branch) begin
                ui       = pc_to_update[bp_pkg::PC_IDX_W-1:0];
                gi       = {g_hist, ui};
                lh       = l_hist[ui];
                g_up     = g_pht[gi][1];
                l_up     = l_pht[lh][1];
                final_up = chooser[ui][1] ? g_up : l_up;
                miss_seen = (final_up != branch_taken);
                // the chooser only learns when the two sides disagree on correctness.
                if ((g_up == branch_taken) != (l_up == branch_taken)) begin
                    chooser[ui] = saturate(chooser[ui], g_up == branch_taken);
                end
                g_pht[gi]  = saturate(g_pht[gi], branch_taken);
                g_hist     = {g_hist[bp_pkg::GHIST_W-2:0], branch_taken};
                l_pht[lh]  = saturate(l_pht[lh], branch_taken);
                l_hist[ui] = {lh[bp_pkg::LHIST_W-2:0], branch_taken};
            end
        end
    end

endmodule

/* bp_control.sv */
`timescale 1ns/100ps

module bp_control (
    input  logic          clk,
    input  logic          rst,
    input  logic          is_branch,
    input  logic          branch_taken,
    input  logic          gsel_pred,
    input  logic          local_pred,
    input  logic          gsel_upd_pred,
    input  logic          local_upd_pred,
    input  bp_pkg::sel_e  sel,
    input  bp_pkg::sel_e  upd_sel,
    output logic          prediction,
    output logic          choice_train,
    output logic          choice_toward_global,
    output bp_pkg::stat_t branch_count,
    output bp_pkg::stat_t mispredict_count
);

    logic upd_prediction;
    logic gsel_right;
    logic local_right;
    logic mispredict;
    logic branch_q;
    logic mispredict_q;

    // the counters stop at all ones rather than wrap.
    function automatic bp_pkg::stat_t stat_inc(bp_pkg::stat_t v, logic en);
        bp_pkg::stat_t nxt;
        nxt = v;
        if (en && v != '1) begin
            nxt = v + 16'd1;
        end
        return nxt;
    endfunction

    assign prediction = (sel == bp_pkg::SEL_GLOBAL) ? gsel_pred : local_pred;

    // the final prediction the pipeline would have used for the resolving branch.
    assign upd_prediction = (upd_sel == bp_pkg::SEL_GLOBAL) ? gsel_upd_pred : local_upd_pred;

    assign gsel_right  = (gsel_upd_pred == branch_taken);
    assign local_right = (local_upd_pred == branch_taken);
    assign mispredict  = is_branch && (upd_prediction != branch_taken);

    // when both sides agree there is nothing to learn about which one to trust.
    assign choice_train         = is_branch && (gsel_right != local_right);
    assign choice_toward_global = gsel_right;

    // the outcome is captured at the update edge and counted one cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_q     <= 1'b0;
            mispredict_q <= 1'b0;
        end else begin
            branch_q     <= is_branch;
            mispredict_q <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_count     <= '0;
            mispredict_count <= '0;
        end else begin
            branch_count     <= stat_inc(branch_count, branch_q);
            mispredict_count <= stat_inc(mispredict_count, mispredict_q);
        end
    end

endmodule

/* bp_pkg.sv */
package bp_pkg;

    localparam int PC_IDX_W = 4; // low pc bits that index the per-pc tables.
    localparam int GHIST_W  = 2;
    localparam int LHIST_W  = 2;

    localparam int GSEL_IDX_W   = GHIST_W + PC_IDX_W;
    localparam int GSEL_ENTRIES = 2 ** GSEL_IDX_W;
    localparam int LHT_ENTRIES  = 2 ** PC_IDX_W;
    localparam int PHT_ENTRIES  = 2 ** LHIST_W; // the local pattern table is shared by all pcs.

    typedef logic [31:0]           pc_t;
    typedef logic [PC_IDX_W-1:0]   pc_idx_t;
    typedef logic [GSEL_IDX_W-1:0] gsel_idx_t;
    typedef logic [GHIST_W-1:0]    ghist_t;
    typedef logic [LHIST_W-1:0]    lhist_t;
    typedef logic [1:0]            ctr_t;
    typedef logic [15:0]           stat_t;

    localparam ctr_t CTR_MIN     = 2'b00;
    localparam ctr_t CTR_MAX     = 2'b11;
    localparam ctr_t CTR_INIT    = 2'b01; // weakly not taken.
    localparam ctr_t CHOICE_INIT = 2'b01; // weakly prefers the local predictor.

    // the chooser decision is the top bit of its counter.
    typedef enum logic {
        SEL_LOCAL  = 1'b0,
        SEL_GLOBAL = 1'b1
    } sel_e;

    function automatic pc_idx_t pc_idx(pc_t pc);
        return pc[PC_IDX_W-1:0];
    endfunction

    // one saturating step of a 2-bit counter, up or down.
    function automatic ctr_t ctr_step(ctr_t c, logic up);
        ctr_t nxt;
        nxt = c;
        if (up && c != CTR_MAX) begin
            nxt = c + 2'd1;
        end else if (!up && c != CTR_MIN) begin
            nxt = c - 2'd1;
        end
        return nxt;
    endfunction

endpackage

/* choice_table.sv */
`timescale 1ns/100ps

module choice_table (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::pc_t   pc_to_predict,
    input  bp_pkg::pc_t   pc_to_update,
    input  logic          choice_train,
    input  logic          choice_toward_global,
    output bp_pkg::sel_e  sel,
    output bp_pkg::sel_e  upd_sel
);

    bp_pkg::ctr_t    cht [bp_pkg::LHT_ENTRIES];
    bp_pkg::pc_idx_t idx_predict;
    bp_pkg::pc_idx_t idx_update;

    assign idx_predict = bp_pkg::pc_idx(pc_to_predict);
    assign idx_update  = bp_pkg::pc_idx(pc_to_update);

    // upper half of the counter range picks the gselect side.
    assign sel     = cht[idx_predict][1] ? bp_pkg::SEL_GLOBAL : bp_pkg::SEL_LOCAL;
    assign upd_sel = cht[idx_update][1] ? bp_pkg::SEL_GLOBAL : bp_pkg::SEL_LOCAL;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::LHT_ENTRIES; i++) begin
                cht[i] <= bp_pkg::CHOICE_INIT;
            end
        end else if (choice_train) begin
            // counting up moves the entry toward global.
            cht[idx_update] <= bp_pkg::ctr_step(cht[idx_update], choice_toward_global);
        end
    end

endmodule

/* gselect_predictor.sv */
`timescale 1ns/100ps

module gselect_predictor (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::pc_t   pc_to_predict,
    input  bp_pkg::pc_t   pc_to_update,
    input  logic          is_branch,
    input  logic          branch_taken,
    output logic          gsel_pred,
    output logic          gsel_upd_pred
);

    bp_pkg::ghist_t    ghist;
    bp_pkg::ctr_t      pht [bp_pkg::GSEL_ENTRIES];
    bp_pkg::gsel_idx_t idx_predict;
    bp_pkg::gsel_idx_t idx_update;

    // both ports see the same history, so lookup and update of one pc hit the same entry.
    assign idx_predict = {ghist, bp_pkg::pc_idx(pc_to_predict)};
    assign idx_update  = {ghist, bp_pkg::pc_idx(pc_to_update)};

    assign gsel_pred     = pht[idx_predict][1];
    assign gsel_upd_pred = pht[idx_update][1]; // what this table said for the branch now resolving.

    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < bp_pkg::GSEL_ENTRIES; i++) begin
                pht[i] <= bp_pkg::CTR_INIT;
            end
        end else if (is_branch) begin
            ghist            <= {ghist[bp_pkg::GHIST_W-2:0], branch_taken};
            pht[idx_update]  <= bp_pkg::ctr_step(pht[idx_update], branch_taken);
        end
    end

endmodule

/* local_predictor.sv */
`timescale 1ns/100ps

module local_predictor (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::pc_t   pc_to_predict,
    input  bp_pkg::pc_t   pc_to_update,
    input  logic          is_branch,
    input  logic          branch_taken,
    output logic          local_pred,
    output logic          local_upd_pred
);

    bp_pkg::lhist_t  lht [bp_pkg::LHT_ENTRIES];
    bp_pkg::ctr_t    pht [bp_pkg::PHT_ENTRIES];
    bp_pkg::pc_idx_t lht_idx_predict;
    bp_pkg::pc_idx_t lht_idx_update;
    bp_pkg::lhist_t  hist_predict;
    bp_pkg::lhist_t  hist_update;

    assign lht_idx_predict = bp_pkg::pc_idx(pc_to_predict);
    assign lht_idx_update  = bp_pkg::pc_idx(pc_to_update);

    // first level: the history this pc has seen.
    assign hist_predict = lht[lht_idx_predict];
    assign hist_update  = lht[lht_idx_update];

    // second level: the shared counters, indexed by that history.
    assign local_pred     = pht[hist_predict][1];
    assign local_upd_pred = pht[hist_update][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::LHT_ENTRIES; i++) begin
                lht[i] <= '0;
            end
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                pht[i] <= bp_pkg::CTR_INIT;
            end
        end else if (is_branch) begin
            // the counter is trained at the old history, then the history moves on.
            pht[hist_update]    <= bp_pkg::ctr_step(pht[hist_update], branch_taken);
            lht[lht_idx_update] <= {hist_update[bp_pkg::LHIST_W-2:0], branch_taken};
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_tournament \
    --Mdir obj_dir -o sim_tournament
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_tournament > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi

echo "pass line not found in $LOG"
exit 1

/* tb_tournament.sv */
`timescale 1ns/100ps

module tb_tournament;

    localparam int NUM_TESTS    = 7;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_HALF     = 10;
    localparam int SCAN_PCS     = 16;

    typedef enum int {
        PAT_TAKEN,
        PAT_NOT_TAKEN,
        PAT_ALTERNATE,
        PAT_CORRELATED,
        PAT_RANDOM
    } pattern_e;

    logic          clk;
    logic          rst;
    bp_pkg::pc_t   pc_to_predict;
    bp_pkg::pc_t   pc_to_update;
    logic          is_branch;
    logic          branch_taken;
    logic          prediction;
    bp_pkg::stat_t branch_count;
    bp_pkg::stat_t mispredict_count;
    logic          expect_valid;
    bp_pkg::stat_t expect_total;
    int            checker_errors;

    // stimulus table, one row per test.
    string         row_name  [NUM_TESTS];
    bp_pkg::pc_t   row_pc    [NUM_TESTS];
    pattern_e      row_kind  [NUM_TESTS];
    int            row_count [NUM_TESTS];
    int            row_gap   [NUM_TESTS];
    int            row_delta [NUM_TESTS];

    bp_pkg::pc_t   seq_pc    [$];
    logic          seq_taken [$];
    int            expected_total;
    int            failed_tests;

    tournament_predictor u_dut (
        .clk              (clk),
        .rst              (rst),
        .pc_to_predict    (pc_to_predict),
        .pc_to_update     (pc_to_update),
        .is_branch        (is_branch),
        .branch_taken     (branch_taken),
        .prediction       (prediction),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    bp_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .pc_to_predict    (pc_to_predict),
        .pc_to_update     (pc_to_update),
        .is_branch        (is_branch),
        .branch_taken     (branch_taken),
        .prediction       (prediction),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count),
        .expect_valid     (expect_valid),
        .expect_total     (expect_total),
        .error_count      (checker_errors)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    task automatic set_row(int r, string name, bp_pkg::pc_t pc, pattern_e kind,
                           int count, int gap, int delta);
        row_name[r]  = name;
        row_pc[r]    = pc;
        row_kind[r]  = kind;
        row_count[r] = count;
        row_gap[r]   = gap;
        row_delta[r] = delta;
    endtask

    task automatic load_table();
        set_row(0, "after_reset",     32'h0000_0f00, PAT_NOT_TAKEN,  0,   0, 0);
        set_row(1, "always_taken",    32'h0000_1000, PAT_TAKEN,      16,  0, 16);
        set_row(2, "never_taken",     32'h0000_2003, PAT_NOT_TAKEN,  8,   1, 8);
        set_row(3, "alternating",     32'h0000_3005, PAT_ALTERNATE,  32,  0, 32);
        set_row(4, "correlated",      32'h0000_4008, PAT_CORRELATED, 48,  0, 48);
        set_row(5, "random_many_pcs", 32'h0001_0000, PAT_RANDOM,     200, 0, 200);
        set_row(6, "idle_gaps",       32'h0000_500c, PAT_ALTERNATE,  12,  3, 12);
    endtask

    // outcomes are made up front so the correlated pattern can look back.
    task automatic build_sequence(int r);
        int unsigned rnd;
        logic        first_taken;
        seq_pc.delete();
        seq_taken.delete();
        first_taken = 1'b0;
        for (int i = 0; i < row_count[r]; i++) begin
            rnd = $urandom();
            case (row_kind[r])
                PAT_TAKEN: begin
                    seq_pc.push_back(row_pc[r]);
                    seq_taken.push_back(1'b1);
                end
                PAT_NOT_TAKEN: begin
                    seq_pc.push_back(row_pc[r]);
                    seq_taken.push_back(1'b0);
                end
                PAT_ALTERNATE: begin
                    seq_pc.push_back(row_pc[r]);
                    seq_taken.push_back(i % 2 == 0);
                end
                PAT_CORRELATED: begin
                    if (i % 2 == 0) begin
                        first_taken = rnd[0];
                        seq_pc.push_back(row_pc[r]);
                        seq_taken.push_back(first_taken);
                    end else begin
                        seq_pc.push_back(row_pc[r] + 32'd1); // repeats the branch before it.
                        seq_taken.push_back(first_taken);
                    end
                end
                default: begin
                    seq_pc.push_back(row_pc[r] + {26'd0, rnd[9:4]});
                    seq_taken.push_back(rnd[0]);
                end
            endcase
        end
        seq_pc.push_back(row_pc[r]);
    endtask

    task automatic run_row(int r);
        int err_start;
        int branch_start;
        int miss_start;
        int errors;
        err_start    = checker_errors;
        branch_start = int'(branch_count);
        miss_start   = int'(mispredict_count);
        build_sequence(r);
        @(negedge clk);
        pc_to_predict = seq_pc[0];
        for (int i = 0; i < row_count[r]; i++) begin
            @(negedge clk);
            pc_to_update  = seq_pc[i];
            branch_taken  = seq_taken[i];
            is_branch     = 1'b1;
            pc_to_predict = seq_pc[i + 1]; // the lookup runs ahead of its own update.
            repeat (row_gap[r]) begin
                @(negedge clk);
                is_branch = 1'b0;
            end
        end
        @(negedge clk);
        is_branch    = 1'b0;
        branch_taken = 1'b0;
        @(negedge clk);
        expected_total = expected_total + row_delta[r];
        expect_total   = bp_pkg::stat_t'(expected_total);
        expect_valid   = 1'b1;
        @(negedge clk);
        expect_valid = 1'b0;
        errors = checker_errors - err_start;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d branches, count +%0d, mispredicts +%0d, errors %0d, %s",
                 r, row_name[r], row_count[r], int'(branch_count) - branch_start,
                 int'(mispredict_count) - miss_start, errors, (errors == 0) ? "ok" : "failed");
    endtask

    initial begin : watchdog
        int cycles;
        @(posedge clk);
        cycles = RESET_CYCLES + SCAN_PCS;
        for (int r = 0; r < NUM_TESTS; r++) begin
            cycles = cycles + row_count[r] * (1 + row_gap[r]) + 4;
        end
        #(cycles * 2 * CLK_HALF * 2 + 2000);
        $display("timeout: the run did not finish within %0d cycles and the margin", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(84390));
        load_table();
        rst            = 1'b1;
        pc_to_predict  = '0;
        pc_to_update   = '0;
        is_branch      = 1'b0;
        branch_taken   = 1'b0;
        expect_valid   = 1'b0;
        expect_total   = '0;
        expected_total = 0;
        failed_tests   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle lookups over a spread of pcs should all read not taken.
        for (int i = 0; i < SCAN_PCS; i++) begin
            @(negedge clk);
            pc_to_predict = 32'h0000_0f00 + i * 7;
        end
        for (int r = 0; r < NUM_TESTS; r++) begin
            run_row(r);
        end
        $display("totals: %0d tests, %0d failed, %0d branches, %0d mispredicts, %0d errors",
                 NUM_TESTS, failed_tests, int'(branch_count), int'(mispredict_count),
                 checker_errors);
        if (failed_tests == 0 && checker_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tournament_predictor.sv */
`timescale 1ns/100ps

module tournament_predictor (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::pc_t   pc_to_predict,
    input  bp_pkg::pc_t   pc_to_update,
    input  logic          is_branch,
    input  logic          branch_taken,
    output logic          prediction,
    output bp_pkg::stat_t branch_count,
    output bp_pkg::stat_t mispredict_count
);

    logic         gsel_pred;
    logic         gsel_upd_pred;
    logic         local_pred;
    logic         local_upd_pred;
    logic         choice_train;
    logic         choice_toward_global;
    bp_pkg::sel_e sel;
    bp_pkg::sel_e upd_sel;

    gselect_predictor u_gselect (
        .clk           (clk),
        .rst           (rst),
        .pc_to_predict (pc_to_predict),
        .pc_to_update  (pc_to_update),
        .is_branch     (is_branch),
        .branch_taken  (branch_taken),
        .gsel_pred     (gsel_pred),
        .gsel_upd_pred (gsel_upd_pred)
    );

    local_predictor u_local (
        .clk            (clk),
        .rst            (rst),
        .pc_to_predict  (pc_to_predict),
        .pc_to_update   (pc_to_update),
        .is_branch      (is_branch),
        .branch_taken   (branch_taken),
        .local_pred     (local_pred),
        .local_upd_pred (local_upd_pred)
    );

    choice_table u_choice (
        .clk                  (clk),
        .rst                  (rst),
        .pc_to_predict        (pc_to_predict),
        .pc_to_update         (pc_to_update),
        .choice_train         (choice_train),
        .choice_toward_global (choice_toward_global),
        .sel                  (sel),
        .upd_sel              (upd_sel)
    );

    bp_control u_control (
        .clk                  (clk),
        .rst                  (rst),
        .is_branch            (is_branch),
        .branch_taken         (branch_taken),
        .gsel_pred            (gsel_pred),
        .local_pred           (local_pred),
        .gsel_upd_pred        (gsel_upd_pred),
        .local_upd_pred       (local_upd_pred),
        .sel                  (sel),
        .upd_sel              (upd_sel),
        .prediction           (prediction),
        .choice_train         (choice_train),
        .choice_toward_global (choice_toward_global),
        .branch_count         (branch_count),
        .mispredict_count     (mispredict_count)
    );

endmodule

/* tournament_props.sv */
`timescale 1ns/100ps

module tournament_props (
    input logic          clk,
    input logic          rst,
    input logic          is_branch,
    input logic          choice_train,
    input bp_pkg::stat_t branch_count,
    input bp_pkg::stat_t mispredict_count
);

    logic branch_seen; // low from reset until the first resolved branch.

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_seen <= 1'b0;
        end else if (is_branch) begin
            branch_seen <= 1'b1;
        end
    end

    train_needs_branch: assert property (
        @(posedge clk) disable iff (rst) choice_train |-> is_branch
    ) else $error("choice_train was high while is_branch was low");

    misses_within_branches: assert property (
        @(posedge clk) disable iff (rst) mispredict_count <= branch_count
    ) else $error("mispredict_count exceeded branch_count");

    counters_idle_after_reset: assert property (
        @(posedge clk) disable iff (rst)
            !branch_seen |-> (branch_count == '0 && mispredict_count == '0)
    ) else $error("a counter moved before the first branch");

endmodule

bind bp_control tournament_props u_props (
    .clk              (clk),
    .rst              (rst),
    .is_branch        (is_branch),
    .choice_train     (choice_train),
    .branch_count     (branch_count),
    .mispredict_count (mispredict_count)
);
